// ==== a2_card_core.f ====
design/a2_card_pkg.sv
design/prio_select.sv
design/a2_bus_sync.sv
design/card_response_merge.sv
design/mem_port_arbiter.sv
design/scanline_dimmer.sv
design/a2_card_core.sv
verification/tb_a2_card_core.sv

// ==== design/a2_bus_sync.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Brings the asynchronous Apple bus clocks and reset into the
// logic clock domain. Each bus clock gets a two-stage
// synchronizer, a denoise filter and edge pulses that line up
// with the change of the clean level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module a2_bus_sync #(
    parameter int DENOISE_LEN = 3
) (
    input  logic clk_logic_w,
    input  logic rst_i,
    input  logic a2_reset_n_i,
    input  logic a2_phi1_i,
    input  logic a2_7m_i,
    output logic system_reset_o,
    output logic phi1_o,
    output logic phi0_o,
    output logic phi1_posedge_o,
    output logic phi1_negedge_o,
    output logic clk_2m_posedge_o,
    output logic clk_7m_o,
    output logic clk_14m_posedge_o
);

    localparam int CNT_W = $clog2(DENOISE_LEN + 1);

    logic [1:0] a2_reset_sync_q;
    wire  [1:0] raw_w = {a2_7m_i, a2_phi1_i};
    wire  [1:0] level_w;
    wire  [1:0] rise_w;
    wire  [1:0] fall_w;

    // Apple reset, two flops
    always_ff @(posedge clk_logic_w) begin
        a2_reset_sync_q <= {a2_reset_sync_q[0], a2_reset_n_i};
    end

    assign system_reset_o = rst_i | ~a2_reset_sync_q[1];

    // Channel 0 is phi1, channel 1 is 7M
    for (genvar ch = 0; ch < 2; ch++) begin : g_denoise
        logic             sync1_q;
        logic             sync2_q;
        logic             level_q;
        logic             rise_q;
        logic             fall_q;
        logic [CNT_W-1:0] cnt_q;

        always_ff @(posedge clk_logic_w) begin
            if (rst_i) begin
                sync1_q <= 1'b0;
                sync2_q <= 1'b0;
                level_q <= 1'b0;
                rise_q  <= 1'b0;
                fall_q  <= 1'b0;
                cnt_q   <= '0;
            end else begin
                sync1_q <= raw_w[ch];
                sync2_q <= sync1_q;
                rise_q  <= 1'b0;
                fall_q  <= 1'b0;
                if (sync2_q == level_q) begin
                    cnt_q <= '0;
                end else if (cnt_q == CNT_W'(DENOISE_LEN - 1)) begin
                    // Enough equal samples, accept the new level
                    cnt_q   <= '0;
                    level_q <= sync2_q;
                    rise_q  <= sync2_q;
                    fall_q  <= ~sync2_q;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end

        assign level_w[ch] = level_q;
        assign rise_w[ch]  = rise_q;
        assign fall_w[ch]  = fall_q;

        // Posedge and negedge pulses of one channel lie DENOISE_LEN cycles apart
        for (genvar d = 1; d < DENOISE_LEN; d++) begin : g_gap
            a_edge_gap: assert property (@(posedge clk_logic_w) disable iff (rst_i)
                (rise_q | fall_q) |-> !$past(rise_q | fall_q, d));
        end
    end

    assign phi1_o            = level_w[0];
    assign phi0_o            = ~level_w[0];
    assign phi1_posedge_o    = rise_w[0];
    assign phi1_negedge_o    = fall_w[0];
    assign clk_2m_posedge_o  = rise_w[0] | fall_w[0];
    assign clk_7m_o          = level_w[1];
    assign clk_14m_posedge_o = rise_w[1] | fall_w[1];

endmodule

// ==== design/a2_card_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Glue core of the Apple II card. Ties together bus clock and
// reset recovery, the card response merge, the memory port
// arbiter and the scanline dimmer. Instances only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module a2_card_core
    import a2_card_pkg::*;
#(
    parameter int NUM_MEM_PORTS = 2,
    parameter int MEM_CREDITS   = 2,
    parameter int DENOISE_LEN   = 3
) (
    input  logic                               clk_logic_w,
    input  logic                               rst_i,
    // Apple bus
    input  logic                               a2_reset_n_i,
    input  logic                               a2_phi1_i,
    input  logic                               a2_7m_i,
    output logic                               system_reset_o,
    output logic                               phi1_o,
    output logic                               phi0_o,
    output logic                               phi1_posedge_o,
    output logic                               phi1_negedge_o,
    output logic                               clk_2m_posedge_o,
    output logic                               clk_7m_o,
    output logic                               clk_14m_posedge_o,
    // Slot cards
    input  logic     [NUM_CARDS-1:0]           card_rd_en_i,
    input  a2_byte_t [NUM_CARDS-1:0]           card_data_i,
    input  logic     [NUM_CARDS-1:0]           card_irq_n_i,
    input  a2_byte_t                           bus_data_i,
    output logic                               data_out_en_o,
    output a2_byte_t                           data_out_o,
    output logic                               irq_n_o,
    // Memory requesters, port 0 is video
    input  logic     [NUM_MEM_PORTS-1:0]       req_valid_i,
    input  mem_req_t [NUM_MEM_PORTS-1:0]       req_i,
    input  logic                               mem_credit_i,
    output logic     [NUM_MEM_PORTS-1:0]       grant_o,
    output logic                               mem_valid_o,
    output mem_req_t                           mem_req_o,
    // Video
    input  rgb_t                               rgb_i,
    input  logic     [SCREEN_Y_W-1:0]          screen_y_i,
    input  logic                               scanlines_en_i,
    output rgb_t                               rgb_o
);

    a2_bus_sync #(
        .DENOISE_LEN(DENOISE_LEN)
    ) u_bus_sync (
        .clk_logic_w      (clk_logic_w),
        .rst_i            (rst_i),
        .a2_reset_n_i     (a2_reset_n_i),
        .a2_phi1_i        (a2_phi1_i),
        .a2_7m_i          (a2_7m_i),
        .system_reset_o   (system_reset_o),
        .phi1_o           (phi1_o),
        .phi0_o           (phi0_o),
        .phi1_posedge_o   (phi1_posedge_o),
        .phi1_negedge_o   (phi1_negedge_o),
        .clk_2m_posedge_o (clk_2m_posedge_o),
        .clk_7m_o         (clk_7m_o),
        .clk_14m_posedge_o(clk_14m_posedge_o)
    );

    card_response_merge u_card_merge (
        .clk_logic_w  (clk_logic_w),
        .rst_i        (rst_i),
        .card_rd_en_i (card_rd_en_i),
        .card_data_i  (card_data_i),
        .card_irq_n_i (card_irq_n_i),
        .bus_data_i   (bus_data_i),
        .data_out_en_o(data_out_en_o),
        .data_out_o   (data_out_o),
        .irq_n_o      (irq_n_o)
    );

    mem_port_arbiter #(
        .NUM_MEM_PORTS(NUM_MEM_PORTS),
        .MEM_CREDITS  (MEM_CREDITS)
    ) u_mem_arb (
        .clk_logic_w (clk_logic_w),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .mem_credit_i(mem_credit_i),
        .grant_o     (grant_o),
        .mem_valid_o (mem_valid_o),
        .mem_req_o   (mem_req_o)
    );

    scanline_dimmer u_dimmer (
        .clk_logic_w   (clk_logic_w),
        .rst_i         (rst_i),
        .rgb_i         (rgb_i),
        .screen_y_i    (screen_y_i),
        .scanlines_en_i(scanlines_en_i),
        .rgb_o         (rgb_o)
    );

endmodule

// ==== design/a2_card_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, counts and payload types of the Apple II
// card glue core. Modules take these by a wildcard import
// in their header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package a2_card_pkg;

    // One byte on the Apple data bus
    typedef logic [7:0] a2_byte_t;

    // Slot cards able to answer a read, index 0 wins
    // (serial, sprite, sound)
    localparam int NUM_CARDS = 3;

    // Memory port geometry
    localparam int MEM_ADDR_W = 21;
    localparam int MEM_DATA_W = 32;
    localparam int MEM_DQM_W  = 4;

    // One memory request, 58 bits
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] wdata;
        logic [MEM_DQM_W-1:0]  dqm;
        logic                  we;
    } mem_req_t;

    // One pixel of the final video stream
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    localparam int SCREEN_Y_W = 10;

endpackage

// ==== design/card_response_merge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decides which slot card drives the Apple data bus and merges
// the open-drain card interrupts. Outputs are registered, one
// cycle after the card inputs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module card_response_merge
    import a2_card_pkg::*;
(
    input  logic                           clk_logic_w,
    input  logic                           rst_i,
    input  logic     [NUM_CARDS-1:0]       card_rd_en_i,
    input  a2_byte_t [NUM_CARDS-1:0]       card_data_i,
    input  logic     [NUM_CARDS-1:0]       card_irq_n_i,
    input  a2_byte_t                       bus_data_i,
    output logic                           data_out_en_o,
    output a2_byte_t                       data_out_o,
    output logic                           irq_n_o
);

    logic     any_rd_w;
    a2_byte_t card_sel_w;

    prio_select #(
        .payload_t(a2_byte_t),
        .N        (NUM_CARDS)
    ) u_card_sel (
        .valid_i  (card_rd_en_i),
        .payload_i(card_data_i),
        .any_o    (any_rd_w),
        .index_o  (),
        .payload_o(card_sel_w)
    );

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            data_out_en_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            data_out_en_o <= any_rd_w;
            irq_n_o       <= &card_irq_n_i;   // wired-AND
        end
    end

    // No reader, echo what the bus carries
    always_ff @(posedge clk_logic_w) begin
        data_out_o <= any_rd_w ? card_sel_w : bus_data_i;
    end

endmodule

// ==== design/mem_port_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arbitrates memory requesters onto a single memory port.
// Lower port number wins. Requests go out only while the
// memory has credit left; each mem_credit_i pulse returns one.
// Grant and issue happen at the same clock edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_port_arbiter
    import a2_card_pkg::*;
#(
    parameter int NUM_MEM_PORTS = 2,
    parameter int MEM_CREDITS   = 2
) (
    input  logic                               clk_logic_w,
    input  logic                               rst_i,
    input  logic     [NUM_MEM_PORTS-1:0]       req_valid_i,
    input  mem_req_t [NUM_MEM_PORTS-1:0]       req_i,
    input  logic                               mem_credit_i,
    output logic     [NUM_MEM_PORTS-1:0]       grant_o,
    output logic                               mem_valid_o,
    output mem_req_t                           mem_req_o
);

    localparam int CRED_W = $clog2(MEM_CREDITS + 1);
    localparam int IDX_W  = $clog2((NUM_MEM_PORTS > 1) ? NUM_MEM_PORTS : 2);

    logic [CRED_W-1:0]        credit_q;
    logic [NUM_MEM_PORTS-1:0] pending_w;
    logic [NUM_MEM_PORTS-1:0] grant_d;
    logic                     any_w;
    logic [IDX_W-1:0]         win_idx_w;
    mem_req_t                 win_req_w;
    logic                     issue_w;

    // A port granted last edge still shows its old request
    assign pending_w = req_valid_i & ~grant_o;

    prio_select #(
        .payload_t(mem_req_t),
        .N        (NUM_MEM_PORTS)
    ) u_req_sel (
        .valid_i  (pending_w),
        .payload_i(req_i),
        .any_o    (any_w),
        .index_o  (win_idx_w),
        .payload_o(win_req_w)
    );

    assign issue_w = any_w && (credit_q != '0);

    always_comb begin
        grant_d = '0;
        if (issue_w) begin
            grant_d[win_idx_w] = 1'b1;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            credit_q    <= CRED_W'(MEM_CREDITS);
            grant_o     <= '0;
            mem_valid_o <= 1'b0;
        end else begin
            grant_o     <= grant_d;
            mem_valid_o <= issue_w;
            // Issue and return together cancel out
            if (issue_w && !mem_credit_i) begin
                credit_q <= credit_q - 1'b1;
            end else if (!issue_w && mem_credit_i) begin
                credit_q <= credit_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (issue_w) begin
            mem_req_o <= win_req_w;
        end
    end

    a_grant_onehot: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        $onehot0(grant_o) && (mem_valid_o == (grant_o != '0)));

    a_credit_max: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        credit_q <= CRED_W'(MEM_CREDITS));

    // An issue never spends credit that was not there
    a_credit_floor: assert property (@(posedge clk_logic_w) disable iff (rst_i)
        mem_valid_o |-> $past(credit_q) != '0);

endmodule

// ==== design/prio_select.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-priority selector. Finds the lowest set valid bit and
// forwards that entry's payload, purely combinational. Used for
// card read data and for memory requests.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module prio_select #(
    parameter type payload_t = logic [7:0],
    parameter int  N         = 2
) (
    input  logic     [N-1:0]                       valid_i,
    input  payload_t [N-1:0]                       payload_i,
    output logic                                   any_o,
    output logic     [$clog2((N > 1) ? N : 2)-1:0] index_o,
    output payload_t                               payload_o
);

    localparam int IDX_W = $clog2((N > 1) ? N : 2);

    // Walk down so the lowest index is written last
    always_comb begin
        any_o     = 1'b0;
        index_o   = '0;
        payload_o = payload_i[0];
        for (int i = N - 1; i >= 0; i--) begin
            if (valid_i[i]) begin
                any_o     = 1'b1;
                index_o   = IDX_W'(i);
                payload_o = payload_i[i];
            end
        end
    end

endmodule

// ==== design/scanline_dimmer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scanline effect on the final RGB stream. Odd screen lines
// are shown at half intensity while enabled. One cycle delay.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scanline_dimmer
    import a2_card_pkg::*;
(
    input  logic                  clk_logic_w,
    input  logic                  rst_i,
    input  rgb_t                  rgb_i,
    input  logic [SCREEN_Y_W-1:0] screen_y_i,
    input  logic                  scanlines_en_i,
    output rgb_t                  rgb_o
);

    wire dim_w = scanlines_en_i & screen_y_i[0];

    always_ff @(posedge clk_logic_w) begin
        if (rst_i) begin
            rgb_o <= '0;
        end else begin
            rgb_o.r <= dim_w ? (rgb_i.r >> 1) : rgb_i.r;
            rgb_o.g <= dim_w ? (rgb_i.g >> 1) : rgb_i.g;
            rgb_o.b <= dim_w ? (rgb_i.b >> 1) : rgb_i.b;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f a2_card_core.f --top-module tb_a2_card_core \
    --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== verification/tb_a2_card_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench of the Apple II card glue core.
// Covers bus clock recovery, reset, card merge, memory
// arbitration with credits and the scanline dimmer. Expected
// values come from reference functions and a cycle model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_a2_card_core
    import a2_card_pkg::*;
();

    localparam int DENOISE_LEN   = 3;
    localparam int NUM_MEM_PORTS = 2;
    localparam int MEM_CREDITS   = 2;
    localparam int HALF_CYCLES   = 9;

    logic                           clk_logic_w;
    logic                           rst_i;
    logic                           a2_reset_n_i;
    logic                           a2_phi1_i;
    logic                           a2_7m_i;
    logic                           system_reset_o;
    logic                           phi1_o;
    logic                           phi0_o;
    logic                           phi1_posedge_o;
    logic                           phi1_negedge_o;
    logic                           clk_2m_posedge_o;
    logic                           clk_7m_o;
    logic                           clk_14m_posedge_o;
    logic     [NUM_CARDS-1:0]       card_rd_en_i;
    a2_byte_t [NUM_CARDS-1:0]       card_data_i;
    logic     [NUM_CARDS-1:0]       card_irq_n_i;
    a2_byte_t                       bus_data_i;
    logic                           data_out_en_o;
    a2_byte_t                       data_out_o;
    logic                           irq_n_o;
    logic     [NUM_MEM_PORTS-1:0]   req_valid_i;
    mem_req_t [NUM_MEM_PORTS-1:0]   req_i;
    logic                           mem_credit_i;
    logic     [NUM_MEM_PORTS-1:0]   grant_o;
    logic                           mem_valid_o;
    mem_req_t                       mem_req_o;
    rgb_t                           rgb_i;
    logic     [SCREEN_Y_W-1:0]      screen_y_i;
    logic                           scanlines_en_i;
    rgb_t                           rgb_o;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'hcfc92aa3;

    // Stream checker state
    logic        pipe_en = 1'b0;
    logic        exp_valid = 1'b0;
    logic [9:0]  exp_merge;
    rgb_t        exp_rgb;

    // Arbiter model state
    logic [NUM_MEM_PORTS-1:0] pend_m = '0;
    int          credit_m = MEM_CREDITS;
    int          outstanding = 0;
    int          issue_count = 0;
    logic        have_pred = 1'b0;
    logic        exp_issue;
    int          exp_idx;
    mem_req_t    exp_req;

    a2_card_core u_dut (.*);

    initial clk_logic_w = 1'b0;
    always #2 clk_logic_w = ~clk_logic_w;

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Returns {enable, data, irq_n}
    function automatic logic [9:0] merge_ref(input logic [NUM_CARDS-1:0] rd,
                                             input a2_byte_t [NUM_CARDS-1:0] data,
                                             input logic [NUM_CARDS-1:0] irq_n,
                                             input a2_byte_t bus);
        logic     found;
        a2_byte_t d;
        found = 1'b0;
        d     = bus;
        for (int c = 0; c < NUM_CARDS; c++) begin
            if (rd[c] && !found) begin
                found = 1'b1;
                d     = data[c];
            end
        end
        return {found, d, (irq_n == '1)};
    endfunction

    function automatic rgb_t dim_ref(input rgb_t p, input logic [SCREEN_Y_W-1:0] y,
                                     input logic en);
        rgb_t q;
        q = p;
        if (en && y[0]) begin
            q.r = {1'b0, p.r[7:1]};
            q.g = {1'b0, p.g[7:1]};
            q.b = {1'b0, p.b[7:1]};
        end
        return q;
    endfunction

    function automatic int pick_ref(input logic [NUM_MEM_PORTS-1:0] pend);
        int   idx;
        logic found;
        idx   = 0;
        found = 1'b0;
        for (int k = 0; k < NUM_MEM_PORTS; k++) begin
            if (pend[k] && !found) begin
                found = 1'b1;
                idx   = k;
            end
        end
        return idx;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic drive_bus_clock(input int ch, input logic v);
        if (ch == 0) begin
            a2_phi1_i <= v;
        end else begin
            a2_7m_i <= v;
        end
    endtask

    task automatic check_bus_clock(input int ch, input logic lvl, input logic hit);
        if (ch == 0) begin
            check_val("phi1_o", 64'(lvl), 64'(phi1_o));
            check_val("phi0_o", 64'(!lvl), 64'(phi0_o));
            check_val("phi1_posedge_o", 64'(hit && lvl), 64'(phi1_posedge_o));
            check_val("phi1_negedge_o", 64'(hit && !lvl), 64'(phi1_negedge_o));
            check_val("clk_2m_posedge_o", 64'(hit), 64'(clk_2m_posedge_o));
        end else begin
            check_val("clk_7m_o", 64'(lvl), 64'(clk_7m_o));
            check_val("clk_14m_posedge_o", 64'(hit), 64'(clk_14m_posedge_o));
        end
    endtask

    // Clean level change, seen DENOISE_LEN+2 cycles later
    task automatic clock_step(input int ch, input logic val);
        @(posedge clk_logic_w);
        drive_bus_clock(ch, val);
        for (int k = 1; k <= HALF_CYCLES; k++) begin
            @(posedge clk_logic_w);
            @(negedge clk_logic_w);
            check_bus_clock(ch, (k >= DENOISE_LEN + 2) ? val : !val, k == DENOISE_LEN + 2);
        end
    endtask

    // Short pulse that the denoise stage must swallow
    task automatic clock_glitch(input int ch, input int width);
        logic base;
        base = (ch == 0) ? phi1_o : clk_7m_o;
        @(posedge clk_logic_w);
        drive_bus_clock(ch, !base);
        for (int k = 1; k <= width + DENOISE_LEN + 4; k++) begin
            @(posedge clk_logic_w);
            if (k == width) begin
                drive_bus_clock(ch, base);
            end
            @(negedge clk_logic_w);
            check_bus_clock(ch, base, 1'b0);
        end
    endtask

    task automatic apple_reset_check();
        int n;
        @(posedge clk_logic_w);
        a2_reset_n_i <= 1'b0;
        n = 0;
        while (system_reset_o !== 1'b1 && n < 4) begin
            @(posedge clk_logic_w);
            @(negedge clk_logic_w);
            n++;
        end
        if (system_reset_o !== 1'b1 || n > 2) begin
            errors++;
            $display("ERROR at %0t ns: system reset did not follow the Apple reset", $time);
        end
        repeat (3) @(negedge clk_logic_w);
        check_val("system_reset_o", 64'(1), 64'(system_reset_o));
        @(posedge clk_logic_w);
        a2_reset_n_i <= 1'b1;
        @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_val("system_reset_o", 64'(1), 64'(system_reset_o));
        @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_val("system_reset_o", 64'(0), 64'(system_reset_o));
    endtask

    task automatic random_stream(input int n);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] p;
        for (int i = 0; i < n; i++) begin
            @(posedge clk_logic_w);
            r = rand32();
            s = rand32();
            p = rand32();
            card_rd_en_i   <= (r[4:3] == 2'b00) ? 3'b000 : r[2:0];
            card_irq_n_i   <= r[9] ? 3'b111 : r[7:5];
            bus_data_i     <= r[31:24];
            card_data_i    <= s[23:0];
            rgb_i          <= p[23:0];
            screen_y_i     <= r[19:10];
            scanlines_en_i <= r[20];
            pipe_en = 1'b1;
        end
        repeat (2) @(posedge clk_logic_w);
        pipe_en = 1'b0;
    endtask

    // Modes: 0 random credits, 1 credits withheld, 2 one credit, 3 drain
    task automatic arb_run(input int n, input int mode);
        logic                     credit_now;
        logic [NUM_MEM_PORTS-1:0] granted;
        logic [63:0]              r;
        for (int i = 0; i < n; i++) begin
            @(negedge clk_logic_w);
            if (have_pred) begin
                check_val("grant_o", 64'(exp_issue ? (1 << exp_idx) : 0), 64'(grant_o));
                check_val("mem_valid_o", 64'(exp_issue), 64'(mem_valid_o));
                if (exp_issue) begin
                    check_val("mem_req_o", 64'(exp_req), 64'(mem_req_o));
                end
                if (mem_valid_o) begin
                    issue_count++;
                    outstanding++;
                end
                if (outstanding > MEM_CREDITS) begin
                    errors++;
                    $display("ERROR at %0t ns: %0d memory requests outstanding, limit %0d",
                             $time, outstanding, MEM_CREDITS);
                end
            end
            // Prediction for the coming edge
            exp_issue  = (credit_m > 0) && (pend_m != '0);
            exp_idx    = pick_ref(pend_m);
            exp_req    = req_i[exp_idx];
            credit_now = mem_credit_i;
            have_pred  = 1'b1;
            @(posedge clk_logic_w);
            if (credit_now) begin
                outstanding--;
            end
            if (exp_issue && !credit_now) begin
                credit_m--;
            end else if (!exp_issue && credit_now) begin
                credit_m++;
            end
            granted = '0;
            if (exp_issue) begin
                granted[exp_idx] = 1'b1;
                pend_m[exp_idx]  = 1'b0;
            end
            // Granted ports hold one more cycle, then may reload
            for (int k = 0; k < NUM_MEM_PORTS; k++) begin
                if (!pend_m[k] && !granted[k]) begin
                    r         = {rand32(), rand32()};
                    pend_m[k] = (mode == 3) ? 1'b0 : ((mode != 0) || r[63]);
                    req_valid_i[k] <= pend_m[k];
                    req_i[k]       <= r[57:0];
                end
            end
            r = {rand32(), rand32()};
            case (mode)
                0:       mem_credit_i <= (credit_m < MEM_CREDITS) && r[0];
                2:       mem_credit_i <= (i == 0);
                3:       mem_credit_i <= (credit_m < MEM_CREDITS);
                default: mem_credit_i <= 1'b0;
            endcase
        end
    endtask

    // Registered stream outputs, one cycle behind the inputs
    always @(negedge clk_logic_w) begin
        if (pipe_en && exp_valid) begin
            check_val("data_out_en_o", 64'(exp_merge[9]), 64'(data_out_en_o));
            check_val("data_out_o", 64'(exp_merge[8:1]), 64'(data_out_o));
            check_val("irq_n_o", 64'(exp_merge[0]), 64'(irq_n_o));
            check_val("rgb_o", 64'(exp_rgb), 64'(rgb_o));
        end
        exp_valid = pipe_en;
        exp_merge = merge_ref(card_rd_en_i, card_data_i, card_irq_n_i, bus_data_i);
        exp_rgb   = dim_ref(rgb_i, screen_y_i, scanlines_en_i);
    end

    initial begin
        rst_i          = 1'b1;
        a2_reset_n_i   = 1'b1;
        a2_phi1_i      = 1'b0;
        a2_7m_i        = 1'b0;
        card_rd_en_i   = '0;
        card_data_i    = '0;
        card_irq_n_i   = '1;
        bus_data_i     = '0;
        req_valid_i    = '0;
        req_i          = '0;
        mem_credit_i   = 1'b0;
        rgb_i          = '0;
        screen_y_i     = '0;
        scanlines_en_i = 1'b0;

        @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_val("system_reset_o", 64'(1), 64'(system_reset_o));
        check_val("data_out_en_o", 64'(0), 64'(data_out_en_o));
        check_val("irq_n_o", 64'(1), 64'(irq_n_o));
        check_val("grant_o", 64'(0), 64'(grant_o));
        check_val("mem_valid_o", 64'(0), 64'(mem_valid_o));
        check_val("rgb_o", 64'(0), 64'(rgb_o));
        check_bus_clock(0, 1'b0, 1'b0);
        check_bus_clock(1, 1'b0, 1'b0);
        @(posedge clk_logic_w);
        rst_i <= 1'b0;
        @(negedge clk_logic_w);
        check_val("system_reset_o", 64'(0), 64'(system_reset_o));

        for (int ch = 0; ch < 2; ch++) begin
            clock_step(ch, 1'b1);
            clock_glitch(ch, 1);
            clock_step(ch, 1'b0);
            clock_glitch(ch, 2);
            clock_step(ch, 1'b1);
            clock_glitch(ch, 2);
            clock_glitch(ch, 1);
            clock_step(ch, 1'b0);
        end

        apple_reset_check();
        random_stream(300);

        arb_run(200, 0);
        arb_run(12, 3);
        issue_count = 0;
        arb_run(10, 1);
        if (issue_count != MEM_CREDITS) begin
            errors++;
            $display("ERROR: %0d requests issued without returned credit, expected %0d",
                     issue_count, MEM_CREDITS);
        end
        for (int c = 0; c < MEM_CREDITS; c++) begin
            issue_count = 0;
            arb_run(5, 2);
            if (issue_count != 1) begin
                errors++;
                $display("ERROR: one returned credit released %0d requests", issue_count);
            end
        end
        arb_run(12, 3);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
